// File: rtl/switch_pkg.sv
package switch_pkg;

    localparam int NUM_PORTS      = 4;
    localparam int NUM_BANKS      = 8;
    localparam int SLOTS_PER_BANK = 4;
    localparam int SLOT_WORDS     = 16;
    localparam int DATA_W         = 16;
    // one entry per slot in the whole switch
    localparam int QUEUE_DEPTH    = 32;

    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int SLOT_W = $clog2(SLOTS_PER_BANK);
    localparam int WORD_W = $clog2(SLOT_WORDS);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // memory address is {bank, slot, word}
    localparam int ADDR_W = BANK_W + SLOT_W + WORD_W;

    typedef logic [PORT_W-1:0] port_idx_t;
    typedef logic [BANK_W-1:0] bank_idx_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;
    typedef logic [WORD_W-1:0] word_idx_t;
    // 1 to 16 words, so one bit wider than a word index
    typedef logic [WORD_W:0]   word_cnt_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic {MODE_STATIC, MODE_SHARED} match_mode_e;
    typedef enum logic {PRIO_LOW, PRIO_HIGH} prio_e;
    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_JOIN} wr_state_e;
    typedef enum logic {RD_IDLE, RD_BUSY} rd_state_e;

    function automatic addr_t slot_addr(bank_idx_t bank, slot_idx_t slot, word_idx_t word);
        return {bank, slot, word};
    endfunction

endpackage

// File: rtl/port_wr_frontend.sv
`timescale 1ns/1ns

module port_wr_frontend import switch_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_vld,
    input  logic              wr_eop,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              resv_vld,
    input  bank_idx_t         resv_bank,
    input  slot_idx_t         resv_slot,
    input  logic              join_ack,
    output logic              full,
    output logic              resv_used,
    output logic              wr_en,
    output addr_t             wr_addr,
    output logic [DATA_W-1:0] wr_word,
    output logic              join_req,
    output port_idx_t         join_dest,
    output prio_e             join_prio,
    output bank_idx_t         join_bank,
    output slot_idx_t         join_slot,
    output word_cnt_t         join_len
);

    wr_state_e state;
    word_cnt_t cnt;
    logic      start;

    // a packet may only start on a held reservation
    assign full  = !(state == WR_IDLE && resv_vld);
    assign start = state == WR_IDLE && resv_vld && wr_vld && wr_sop;

    // header goes to word 0, the rest follow the word counter
    assign wr_en   = start || (state == WR_DATA && wr_vld);
    assign wr_addr = (state == WR_IDLE) ? slot_addr(resv_bank, resv_slot, '0)
                                        : slot_addr(join_bank, join_slot, cnt[WORD_W-1:0]);
    assign wr_word = wr_data;

    assign join_req  = state == WR_JOIN;
    assign join_len  = cnt;
    // matcher may look for a new slot once the descriptor is queued
    assign resv_used = join_req && join_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (start) begin
                        cnt   <= word_cnt_t'(1);
                        state <= wr_eop ? WR_JOIN : WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wr_vld) begin
                        cnt <= cnt + 1'b1;
                        if (wr_eop) begin
                            state <= WR_JOIN;
                        end
                    end
                end
                WR_JOIN: begin
                    if (join_ack) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // descriptor fields, held until the join is acknowledged
    always_ff @(posedge clk) begin
        if (start) begin
            join_bank <= resv_bank;
            join_slot <= resv_slot;
            join_dest <= wr_data[PORT_W-1:0];
            join_prio <= prio_e'(wr_data[2]);
        end
    end

endmodule

// File: rtl/bank_matcher.sv
`timescale 1ns/1ns

module bank_matcher import switch_pkg::*; #(
    parameter int PORT_IDX = 0
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  match_mode_e                              match_mode,
    input  bank_idx_t                                time_stamp,
    input  logic [NUM_BANKS-1:0][SLOTS_PER_BANK-1:0] bank_busy,
    input  logic                                     resv_used,
    output logic                                     claim,
    output bank_idx_t                                claim_bank,
    output slot_idx_t                                claim_slot,
    output logic                                     resv_vld,
    output bank_idx_t                                resv_bank,
    output slot_idx_t                                resv_slot
);

    logic slot_free;

    // port offset plus timestamp keeps every port on a different bank each cycle
    always_comb begin
        if (match_mode == MODE_STATIC) begin
            // own pair of banks only
            claim_bank = bank_idx_t'(PORT_IDX * 2) + bank_idx_t'(time_stamp[0]);
        end else begin
            claim_bank = time_stamp + bank_idx_t'(PORT_IDX * 2);
        end
    end

    // first free slot wins, scanned downwards so the lowest sticks
    always_comb begin
        claim_slot = '0;
        for (int s = SLOTS_PER_BANK - 1; s >= 0; s--) begin
            if (!bank_busy[claim_bank][s]) begin
                claim_slot = slot_idx_t'(s);
            end
        end
    end

    assign slot_free = !(&bank_busy[claim_bank]);
    // no claim while the switch is held in reset
    assign claim     = rst_n && !resv_vld && slot_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resv_vld <= 1'b0;
        end else if (claim) begin
            resv_vld <= 1'b1;
        end else if (resv_used) begin
            resv_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (claim) begin
            resv_bank <= claim_bank;
            resv_slot <= claim_slot;
        end
    end

endmodule

// File: rtl/buffer_banks.sv
`timescale 1ns/1ns

module buffer_banks import switch_pkg::*; (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic      [NUM_PORTS-1:0]                claim,
    input  bank_idx_t [NUM_PORTS-1:0]                claim_bank,
    input  slot_idx_t [NUM_PORTS-1:0]                claim_slot,
    input  logic      [NUM_PORTS-1:0]                wr_en,
    input  addr_t     [NUM_PORTS-1:0]                wr_addr,
    input  logic      [NUM_PORTS-1:0][DATA_W-1:0]    wr_word,
    input  logic      [NUM_PORTS-1:0]                rd_req,
    input  addr_t     [NUM_PORTS-1:0]                rd_addr,
    input  logic      [NUM_PORTS-1:0]                rel_vld,
    input  bank_idx_t [NUM_PORTS-1:0]                rel_bank,
    input  slot_idx_t [NUM_PORTS-1:0]                rel_slot,
    output bank_idx_t                                time_stamp,
    output logic [NUM_BANKS-1:0][SLOTS_PER_BANK-1:0] bank_busy,
    output logic      [NUM_PORTS-1:0]                rd_grant,
    output logic      [NUM_PORTS-1:0][DATA_W-1:0]    rd_word
);

    logic [DATA_W-1:0] mem [NUM_BANKS*SLOTS_PER_BANK*SLOT_WORDS];
    port_idx_t         rd_sel;

    // free running, drives both the match rotation and the read slots
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            time_stamp <= '0;
        end else begin
            time_stamp <= time_stamp + 1'b1;
        end
    end

    // output d owns the read port when time_stamp mod 4 == d
    assign rd_sel = port_idx_t'(time_stamp);

    always_comb begin
        for (int d = 0; d < NUM_PORTS; d++) begin
            rd_grant[d] = rd_sel == port_idx_t'(d);
        end
    end

    // matchers never share a bank in a cycle, so claims cannot collide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_busy <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rel_vld[p]) begin
                    bank_busy[rel_bank[p]][rel_slot[p]] <= 1'b0;
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (claim[p]) begin
                    bank_busy[claim_bank[p]][claim_slot[p]] <= 1'b1;
                end
            end
        end
    end

    // each writer owns its own reserved slot
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr_en[p]) begin
                mem[wr_addr[p]] <= wr_word[p];
            end
        end
    end

    // single read port, only the granted output is served
    always_ff @(posedge clk) begin
        if (rd_req[rd_sel]) begin
            rd_word[rd_sel] <= mem[rd_addr[rd_sel]];
        end
    end

endmodule

// File: rtl/output_port.sv
`timescale 1ns/1ns

module output_port import switch_pkg::*; #(
    parameter int PORT_IDX = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ready,
    input  logic      [NUM_PORTS-1:0] join_req,
    input  port_idx_t [NUM_PORTS-1:0] join_dest,
    input  logic      [NUM_PORTS-1:0] join_prio,
    input  bank_idx_t [NUM_PORTS-1:0] join_bank,
    input  slot_idx_t [NUM_PORTS-1:0] join_slot,
    input  word_cnt_t [NUM_PORTS-1:0] join_len,
    input  logic                      rd_grant,
    input  logic [DATA_W-1:0]         rd_word,
    output logic      [NUM_PORTS-1:0] join_ack,
    output logic                      rd_req,
    output addr_t                     rd_addr,
    output logic                      rel_vld,
    output bank_idx_t                 rel_bank,
    output slot_idx_t                 rel_slot,
    output logic                      rd_sop,
    output logic                      rd_eop,
    output logic                      rd_vld,
    output logic [DATA_W-1:0]         rd_data
);

    typedef struct packed {
        bank_idx_t bank;
        slot_idx_t slot;
        word_cnt_t len;
    } desc_t;

    // queue 0 is low priority, queue 1 high
    desc_t               fifo [2][QUEUE_DEPTH];
    logic [1:0][QPTR_W:0] wr_ptr;
    logic [1:0][QPTR_W:0] rd_ptr;
    logic [1:0]          q_empty;
    logic                join_vld;
    logic                join_q;
    port_idx_t           join_src;
    logic                pop_hi;
    desc_t               head;
    desc_t               cur;
    desc_t               cur_d;
    word_cnt_t           idx;
    word_cnt_t           cur_idx;
    logic                last;
    rd_state_e           state;

    // lowest numbered port wins when several target this output
    always_comb begin
        join_vld = 1'b0;
        join_src = '0;
        for (int p = NUM_PORTS - 1; p >= 0; p--) begin
            if (join_req[p] && join_dest[p] == port_idx_t'(PORT_IDX)) begin
                join_vld = 1'b1;
                join_src = port_idx_t'(p);
            end
        end
        join_ack           = '0;
        join_ack[join_src] = join_vld;
    end

    assign join_q     = join_prio[join_src];
    assign q_empty[0] = wr_ptr[0] == rd_ptr[0];
    assign q_empty[1] = wr_ptr[1] == rd_ptr[1];
    // strict priority
    assign pop_hi     = !q_empty[PRIO_HIGH];
    assign head       = fifo[pop_hi][rd_ptr[pop_hi][QPTR_W-1:0]];

    // an idle sequencer reads straight from the queue head
    assign cur_d   = (state == RD_IDLE) ? head : cur;
    assign cur_idx = (state == RD_IDLE) ? '0 : idx;
    assign last    = cur_idx == cur_d.len - 1'b1;
    assign rd_req  = rd_grant && ready && (state == RD_BUSY || q_empty != 2'b11);
    assign rd_addr = slot_addr(cur_d.bank, cur_d.slot, cur_idx[WORD_W-1:0]);

    // slot is freed together with its last read
    assign rel_vld  = rd_req && last;
    assign rel_bank = cur_d.bank;
    assign rel_slot = cur_d.slot;
    assign rd_data  = rd_word;

    always_ff @(posedge clk) begin
        if (join_vld) begin
            fifo[join_q][wr_ptr[join_q][QPTR_W-1:0]] <= '{bank: join_bank[join_src],
                                                          slot: join_slot[join_src],
                                                          len:  join_len[join_src]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (join_vld) begin
                wr_ptr[join_q] <= wr_ptr[join_q] + 1'b1;
            end
            if (rd_req && state == RD_IDLE) begin
                rd_ptr[pop_hi] <= rd_ptr[pop_hi] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= RD_IDLE;
            idx    <= '0;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            // flags line up with rd_word one cycle after the read
            rd_vld <= rd_req;
            rd_sop <= rd_req && cur_idx == '0;
            rd_eop <= rel_vld;
            if (rd_req) begin
                state <= last ? RD_IDLE : RD_BUSY;
                idx   <= cur_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            cur <= cur_d;
        end
    end

endmodule

// File: rtl/switch_top.sv
`timescale 1ns/1ns

module switch_top import switch_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_PORTS-1:0]             wr_sop,
    input  logic [NUM_PORTS-1:0]             wr_vld,
    input  logic [NUM_PORTS-1:0]             wr_eop,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data,
    output logic [NUM_PORTS-1:0]             full,
    input  logic [NUM_PORTS-1:0]             ready,
    output logic [NUM_PORTS-1:0]             rd_sop,
    output logic [NUM_PORTS-1:0]             rd_eop,
    output logic [NUM_PORTS-1:0]             rd_vld,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data,
    input  match_mode_e                      match_mode
);

    bank_idx_t                                time_stamp;
    logic [NUM_BANKS-1:0][SLOTS_PER_BANK-1:0] bank_busy;
    logic      [NUM_PORTS-1:0]                claim;
    bank_idx_t [NUM_PORTS-1:0]                claim_bank;
    slot_idx_t [NUM_PORTS-1:0]                claim_slot;
    logic      [NUM_PORTS-1:0]                resv_vld;
    bank_idx_t [NUM_PORTS-1:0]                resv_bank;
    slot_idx_t [NUM_PORTS-1:0]                resv_slot;
    logic      [NUM_PORTS-1:0]                resv_used;
    logic      [NUM_PORTS-1:0]                wr_en;
    addr_t     [NUM_PORTS-1:0]                wr_addr;
    logic      [NUM_PORTS-1:0][DATA_W-1:0]    wr_word;
    logic      [NUM_PORTS-1:0]                join_req;
    port_idx_t [NUM_PORTS-1:0]                join_dest;
    logic      [NUM_PORTS-1:0]                join_prio;
    bank_idx_t [NUM_PORTS-1:0]                join_bank;
    slot_idx_t [NUM_PORTS-1:0]                join_slot;
    word_cnt_t [NUM_PORTS-1:0]                join_len;
    logic      [NUM_PORTS-1:0]                join_ack;
    // acknowledge vector of each output, indexed [output][input]
    logic      [NUM_PORTS-1:0][NUM_PORTS-1:0] ack_by_out;
    logic      [NUM_PORTS-1:0]                rd_req;
    addr_t     [NUM_PORTS-1:0]                rd_addr;
    logic      [NUM_PORTS-1:0]                rel_vld;
    bank_idx_t [NUM_PORTS-1:0]                rel_bank;
    slot_idx_t [NUM_PORTS-1:0]                rel_slot;
    logic      [NUM_PORTS-1:0]                rd_grant;
    logic      [NUM_PORTS-1:0][DATA_W-1:0]    rd_word;

    // an input's request goes to exactly one output, so OR is enough
    always_comb begin
        join_ack = '0;
        for (int d = 0; d < NUM_PORTS; d++) begin
            join_ack = join_ack | ack_by_out[d];
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        port_wr_frontend u_frontend (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[p]), .wr_vld(wr_vld[p]), .wr_eop(wr_eop[p]), .wr_data(wr_data[p]),
            .resv_vld(resv_vld[p]), .resv_bank(resv_bank[p]), .resv_slot(resv_slot[p]),
            .join_ack(join_ack[p]), .full(full[p]), .resv_used(resv_used[p]),
            .wr_en(wr_en[p]), .wr_addr(wr_addr[p]), .wr_word(wr_word[p]),
            .join_req(join_req[p]), .join_dest(join_dest[p]), .join_prio(join_prio[p]),
            .join_bank(join_bank[p]), .join_slot(join_slot[p]), .join_len(join_len[p])
        );

        bank_matcher #(.PORT_IDX(p)) u_matcher (
            .clk(clk), .rst_n(rst_n), .match_mode(match_mode),
            .time_stamp(time_stamp), .bank_busy(bank_busy), .resv_used(resv_used[p]),
            .claim(claim[p]), .claim_bank(claim_bank[p]), .claim_slot(claim_slot[p]),
            .resv_vld(resv_vld[p]), .resv_bank(resv_bank[p]), .resv_slot(resv_slot[p])
        );
    end

    buffer_banks u_banks (
        .clk(clk), .rst_n(rst_n),
        .claim(claim), .claim_bank(claim_bank), .claim_slot(claim_slot),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_word(wr_word),
        .rd_req(rd_req), .rd_addr(rd_addr),
        .rel_vld(rel_vld), .rel_bank(rel_bank), .rel_slot(rel_slot),
        .time_stamp(time_stamp), .bank_busy(bank_busy),
        .rd_grant(rd_grant), .rd_word(rd_word)
    );

    for (genvar d = 0; d < NUM_PORTS; d++) begin : g_out
        output_port #(.PORT_IDX(d)) u_output (
            .clk(clk), .rst_n(rst_n), .ready(ready[d]),
            .join_req(join_req), .join_dest(join_dest), .join_prio(join_prio),
            .join_bank(join_bank), .join_slot(join_slot), .join_len(join_len),
            .rd_grant(rd_grant[d]), .rd_word(rd_word[d]), .join_ack(ack_by_out[d]),
            .rd_req(rd_req[d]), .rd_addr(rd_addr[d]),
            .rel_vld(rel_vld[d]), .rel_bank(rel_bank[d]), .rel_slot(rel_slot[d]),
            .rd_sop(rd_sop[d]), .rd_eop(rd_eop[d]), .rd_vld(rd_vld[d]), .rd_data(rd_data[d])
        );
    end

endmodule

// File: verif/switch_chk.sv
`timescale 1ns/1ns

module switch_chk import switch_pkg::*; (
    input logic                                     clk,
    input logic                                     rst_n,
    input logic      [NUM_PORTS-1:0]                rd_sop,
    input logic      [NUM_PORTS-1:0]                rd_vld,
    input logic      [NUM_PORTS-1:0]                claim,
    input bank_idx_t [NUM_PORTS-1:0]                claim_bank,
    input slot_idx_t [NUM_PORTS-1:0]                claim_slot,
    input logic [NUM_BANKS-1:0][SLOTS_PER_BANK-1:0] bank_busy,
    input logic      [NUM_PORTS-1:0]                join_req,
    input logic      [NUM_PORTS-1:0]                join_ack
);

    int fail_cnt = 0;

    a_sop_vld: assert property (@(posedge clk) disable iff (!rst_n) (rd_sop & ~rd_vld) == '0)
        else begin
            $error("rd_sop seen without rd_vld");
            fail_cnt++;
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        a_claim_free: assert property (@(posedge clk) disable iff (!rst_n)
            claim[p] |-> !bank_busy[claim_bank[p]][claim_slot[p]])
            else begin
                $error("port %0d claimed a busy slot", p);
                fail_cnt++;
            end

        // descriptor stays offered until an output takes it
        a_join_hold: assert property (@(posedge clk) disable iff (!rst_n)
            join_req[p] && !join_ack[p] |=> join_req[p])
            else begin
                $error("port %0d dropped join_req before join_ack", p);
                fail_cnt++;
            end
    end

endmodule

bind switch_top switch_chk chk0 (
    .clk(clk),
    .rst_n(rst_n),
    .rd_sop(rd_sop),
    .rd_vld(rd_vld),
    .claim(claim),
    .claim_bank(claim_bank),
    .claim_slot(claim_slot),
    .bank_busy(bank_busy),
    .join_req(join_req),
    .join_ack(join_ack)
);

// File: verif/switch_tb.sv
`timescale 1ns/1ns

module switch_tb import switch_pkg::*; ();

    logic                             clk;
    logic                             rst_n;
    logic [NUM_PORTS-1:0]             wr_sop;
    logic [NUM_PORTS-1:0]             wr_vld;
    logic [NUM_PORTS-1:0]             wr_eop;
    logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data;
    logic [NUM_PORTS-1:0]             full;
    logic [NUM_PORTS-1:0]             ready;
    logic [NUM_PORTS-1:0]             rd_sop;
    logic [NUM_PORTS-1:0]             rd_eop;
    logic [NUM_PORTS-1:0]             rd_vld;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data;
    match_mode_e                      match_mode;

    integer            seed       = 93684;
    int                errors     = 0;
    int                next_id    = 0;
    int                pending    = 0;
    int                accepted   = 0;
    int                port_accepted [NUM_PORTS];
    logic              traffic_on = 1'b0;
    // sent packets by id, header word first
    logic [DATA_W-1:0] pkt_data [256][SLOT_WORDS];
    int                pkt_len  [256];
    // expected ids per output and priority
    int                exp_q    [NUM_PORTS][2][$];
    logic [DATA_W-1:0] rx_order [NUM_PORTS][$];
    logic [DATA_W-1:0] last_hdr [NUM_PORTS];
    int                cur_id   [NUM_PORTS];
    int                widx     [NUM_PORTS];
    logic              active   [NUM_PORTS];

    switch_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic apply_reset(input match_mode_e mode);
        rst_n      = 1'b0;
        match_mode = mode;
        wr_sop     = '0;
        wr_vld     = '0;
        wr_eop     = '0;
        wr_data    = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic wait_not_full(input int p, input int limit, output bit ok);
        int n;
        n = 0;
        while (full[p] && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        ok = !full[p];
    endtask

    task automatic send_packet(input int p, input int dest, input int prio, input int len,
                               input bit gaps, output bit ok);
        int id;
        int w;
        wait_not_full(p, 2000, ok);
        assert (ok) else begin
            $display("port %0d stayed full, packet was not sent", p);
            errors++;
        end
        if (ok) begin
            id = next_id;
            next_id++;
            pkt_len[id] = len;
            // header carries id and source so the monitor can find the packet
            pkt_data[id][0] = {id[10:0], p[1:0], prio[0], dest[1:0]};
            for (w = 1; w < len; w++) begin
                pkt_data[id][w] = DATA_W'($random(seed));
            end
            exp_q[dest][prio].push_back(id);
            last_hdr[p] = pkt_data[id][0];
            pending++;
            for (w = 0; w < len; w++) begin
                wr_sop[p]  = (w == 0);
                wr_vld[p]  = 1'b1;
                wr_eop[p]  = (w == len - 1);
                wr_data[p] = pkt_data[id][w];
                @(posedge clk);
                #2;
                wr_sop[p] = 1'b0;
                wr_vld[p] = 1'b0;
                wr_eop[p] = 1'b0;
                // occasional idle cycle between words
                if (gaps && ($random(seed) & 3) == 0) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
    endtask

    task automatic check_word(input int d);
        int q;
        int k;
        int pos;
        int id;
        if (rd_sop[d]) begin
            assert (!active[d]) else begin
                $display("output %0d started a packet before the previous one ended", d);
                errors++;
            end
            rx_order[d].push_back(rd_data[d]);
            q   = rd_data[d][2];
            pos = -1;
            // oldest packet from the same source in this queue
            for (k = exp_q[d][q].size() - 1; k >= 0; k--) begin
                if (pkt_data[exp_q[d][q][k]][0][4:3] == rd_data[d][4:3]) begin
                    pos = k;
                end
            end
            active[d] = 1'b0;
            assert (pos >= 0) else begin
                $display("output %0d delivered a packet that was never sent to it", d);
                errors++;
            end
            if (pos >= 0) begin
                cur_id[d] = exp_q[d][q][pos];
                exp_q[d][q].delete(pos);
                widx[d]   = 0;
                active[d] = 1'b1;
            end
        end
        if (active[d]) begin
            id = cur_id[d];
            assert (rd_data[d] == pkt_data[id][widx[d]]) else begin
                $display("[ERROR] rd_data[%0d] got %h expected %h",
                         d, rd_data[d], pkt_data[id][widx[d]]);
                errors++;
            end
            assert (rd_eop[d] == (widx[d] == pkt_len[id] - 1)) else begin
                $display("[ERROR] rd_eop[%0d] got %h expected %h",
                         d, rd_eop[d], (widx[d] == pkt_len[id] - 1));
                errors++;
            end
            widx[d]++;
            if (rd_eop[d] || widx[d] == pkt_len[id]) begin
                active[d] = 1'b0;
                pending--;
            end
        end else if (!rd_sop[d]) begin
            assert (0) else begin
                $display("output %0d gave a word outside any packet", d);
                errors++;
            end
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rst_n) begin
            for (int d = 0; d < NUM_PORTS; d++) begin
                if (rd_vld[d]) begin
                    check_word(d);
                end
            end
        end
    end

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (pending != 0 && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        assert (pending == 0) else begin
            $display("timed out with %0d packets still undelivered", pending);
            errors++;
        end
    endtask

    task automatic send_to_all(input int p);
        bit ok;
        // lengths 1 to 16 spread over the port pairs
        for (int d = 0; d < NUM_PORTS; d++) begin
            send_packet(p, d, d & 1, 1 + ((p * 4 + d) * 5) % 16, 1'b0, ok);
        end
    endtask

    task automatic test_forwarding(input match_mode_e mode);
        apply_reset(mode);
        ready = '1;
        fork
            send_to_all(0);
            send_to_all(1);
            send_to_all(2);
            send_to_all(3);
        join
        wait_drain(4000);
    endtask

    task automatic test_priority();
        bit                ok;
        logic [DATA_W-1:0] hi_hdr;
        ready = 4'b0111;
        rx_order[3].delete();
        send_packet(0, 3, 0, 6, 1'b0, ok);
        send_packet(0, 3, 1, 3, 1'b0, ok);
        hi_hdr = last_hdr[0];
        // full falls only once the second join was taken
        wait_not_full(0, 200, ok);
        assert (ok) else begin
            $display("port 0 stayed full after the priority packets");
            errors++;
        end
        ready = '1;
        wait_drain(2000);
        assert (rx_order[3].size() == 2) else begin
            $display("output 3 did not deliver both priority packets");
            errors++;
        end
        assert (rx_order[3][0] == hi_hdr) else begin
            $display("[ERROR] rd_data[3] first header got %h expected %h", rx_order[3][0], hi_hdr);
            errors++;
        end
    endtask

    task automatic test_order();
        bit                ok;
        logic [DATA_W-1:0] sent [5];
        ready = 4'b1110;
        rx_order[0].delete();
        for (int i = 0; i < 5; i++) begin
            send_packet(2, 0, 1, 2 + i * 3, 1'b1, ok);
            sent[i] = last_hdr[2];
        end
        ready = '1;
        wait_drain(2000);
        for (int i = 0; i < 5; i++) begin
            assert (rx_order[0][i] == sent[i]) else begin
                $display("[ERROR] rd_data[0] header %0d got %h expected %h",
                         i, rx_order[0][i], sent[i]);
                errors++;
            end
        end
    endtask

    task automatic test_static_capacity();
        bit ok;
        apply_reset(MODE_STATIC);
        ready = '0;
        for (int i = 0; i < 8; i++) begin
            send_packet(0, 1, 0, 4, 1'b0, ok);
        end
        // both own banks now hold queued packets
        wait_not_full(0, 100, ok);
        assert (!ok) else begin
            $display("port 0 offered room for a ninth packet in static mode");
            errors++;
        end
        ready[1] = 1'b1;
        wait_not_full(0, 400, ok);
        assert (ok) else begin
            $display("full on port 0 did not fall after output 1 resumed");
            errors++;
        end
        ready = '1;
        wait_drain(2000);
    endtask

    task automatic fill_port(input int p);
        bit ok;
        int n;
        n = 0;
        wait_not_full(p, 64, ok);
        while (ok && n < 40) begin
            send_packet(p, 2, p & 1, 1 + p * 5, 1'b0, ok);
            if (ok) begin
                accepted++;
                port_accepted[p]++;
            end
            n++;
            wait_not_full(p, 64, ok);
        end
    endtask

    task automatic test_shared_capacity();
        apply_reset(MODE_SHARED);
        ready    = '0;
        accepted = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_accepted[p] = 0;
        end
        fork
            fill_port(0);
            fill_port(1);
            fill_port(2);
            fill_port(3);
        join
        assert (accepted == NUM_BANKS * SLOTS_PER_BANK) else begin
            $display("[ERROR] accepted count got %h expected %h",
                     accepted, NUM_BANKS * SLOTS_PER_BANK);
            errors++;
        end
        // shortest packets let port 0 spill past its own two banks
        assert (port_accepted[0] > 2 * SLOTS_PER_BANK) else begin
            $display("port 0 never stored more than its own two banks hold in shared mode");
            errors++;
        end
        ready = '1;
        wait_drain(6000);
    endtask

    task automatic random_port(input int p);
        bit ok;
        for (int i = 0; i < 12; i++) begin
            send_packet(p, $random(seed) & 3, $random(seed) & 1, 1 + ($random(seed) & 15),
                        1'b1, ok);
        end
    endtask

    task automatic toggle_ready();
        for (int n = 0; n < 50000 && traffic_on; n++) begin
            @(posedge clk);
            #2;
            ready = NUM_PORTS'($random(seed));
        end
    endtask

    task automatic test_random();
        traffic_on = 1'b1;
        fork
            begin
                fork
                    random_port(0);
                    random_port(1);
                    random_port(2);
                    random_port(3);
                join
                traffic_on = 1'b0;
            end
            toggle_ready();
        join
        ready = '1;
        wait_drain(20000);
    endtask

    initial begin
        rst_n      = 1'b0;
        wr_sop     = '0;
        wr_vld     = '0;
        wr_eop     = '0;
        wr_data    = '0;
        ready      = '0;
        match_mode = MODE_STATIC;
        for (int d = 0; d < NUM_PORTS; d++) begin
            active[d] = 1'b0;
        end
        test_forwarding(MODE_STATIC);
        test_priority();
        test_order();
        test_static_capacity();
        test_forwarding(MODE_SHARED);
        test_shared_capacity();
        test_random();
        $display("errors: %0d in testbench checks, %0d in protocol assertions",
                 errors, dut0.chk0.fail_cnt);
        if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: switch_top.f
rtl/switch_pkg.sv
rtl/port_wr_frontend.sv
rtl/bank_matcher.sv
rtl/buffer_banks.sv
rtl/output_port.sv
rtl/switch_top.sv
verif/switch_chk.sv
verif/switch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= switch_tb
FILELIST  ?= switch_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^\*\*\* TEST PASSED \*\*\*$$' $(LOG) && echo "simulation ok" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
